/* design/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath widths
`define WORD_WIDTH      16
`define REG_ADDR_WIDTH  2
`define NUM_REGS        4
`define IMM_WIDTH       8
`define JMP_WIDTH       12

`define RESET_PC        16'h0000

// instruction fields
`define OP_FIELD        15:12
`define RS_FIELD        11:10
`define RT_FIELD        9:8
`define RD_FIELD        7:6
`define FUNCT_FIELD     5:0
`define IMM_FIELD       7:0
`define JMP_FIELD       11:0

`endif

/* design/cpu_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_e;

    // first four follow the low funct bits
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_PASS_B = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic    alu_src;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    reg_write;
        logic    wwd;
        logic    halt;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rs_data;
        word_t    rt_data;
        word_t    imm;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t dest;
    } mem_wb_t;

endpackage

`default_nettype wire

/* design/wb_bus_if.sv */
`default_nettype none

interface wb_bus_if;
    import cpu_pkg::*;

    logic     valid;      // data is the final result
    logic     reg_write;  // producer will write dest
    reg_idx_t dest;
    word_t    data;

    modport source (
        output valid,
        output reg_write,
        output dest,
        output data
    );

    modport sink (
        input valid,
        input reg_write,
        input dest,
        input data
    );

endinterface

`default_nettype wire

/* design/pipe_reg.sv */
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     hold,
    input  logic     bubble,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid & ~bubble;
        end
    end

    // contents of a bubble don't matter
    always_ff @(posedge clk) begin
        if (!hold && !bubble) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* design/register_file.sv */
`default_nettype none

`include "cpu_defines.svh"

module register_file (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    output cpu_pkg::word_t    rs_data,
    output cpu_pkg::word_t    rt_data,
    wb_bus_if.sink            wb
);
    import cpu_pkg::*;

    word_t regs [`NUM_REGS];
    logic  we;

    assign we = wb.valid & wb.reg_write;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through, covers the writeback hazard
    assign rs_data = (we && wb.dest == rs) ? wb.data : regs[rs];
    assign rt_data = (we && wb.dest == rt) ? wb.data : regs[rt];

endmodule

`default_nettype wire

/* design/decode_unit.sv */
`default_nettype none

`include "cpu_defines.svh"

module decode_unit (
    input  cpu_pkg::word_t    inst,
    input  logic              inst_valid,
    input  cpu_pkg::word_t    pc,
    input  cpu_pkg::word_t    rs_data,
    input  cpu_pkg::word_t    rt_data,
    input  cpu_pkg::ctrl_t    ex_ctrl,
    input  cpu_pkg::reg_idx_t ex_dest,
    input  logic              ex_valid,
    wb_bus_if.sink            ex_res,
    wb_bus_if.sink            mem_fwd,
    output cpu_pkg::id_ex_t   id_ex_out,
    output logic              stall,
    output logic              redirect,
    output cpu_pkg::word_t    target,
    output logic              halt_seen
);
    import cpu_pkg::*;

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    reg_idx_t dest;
    word_t    imm_ext;
    word_t    br_a;
    word_t    br_b;
    ctrl_t    ctrl;
    logic     use_rs;
    logic     use_rt;
    logic     is_branch;
    logic     is_jump;
    logic     taken;
    logic     load_hit;
    logic     mem_pending;
    logic     ex_fwd;
    logic     mem_ok;

    assign opcode  = opcode_e'(inst[`OP_FIELD]);
    assign funct   = funct_e'(inst[`FUNCT_FIELD]);
    assign rs      = inst[`RS_FIELD];
    assign rt      = inst[`RT_FIELD];
    assign rd      = inst[`RD_FIELD];
    assign imm_ext = {{(`WORD_WIDTH-`IMM_WIDTH){inst[`IMM_WIDTH-1]}}, inst[`IMM_FIELD]};

    ////////////////////////////////////////////////////////////////////////////
    // control decode

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        dest        = rt;
        use_rs      = 1'b0;
        use_rt      = 1'b0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dest = rd;
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_op_e'(funct[2:0]);
                        use_rs         = 1'b1;
                        use_rt         = 1'b1;
                    end
                    FN_WWD: begin
                        ctrl.wwd    = 1'b1;
                        ctrl.alu_op = ALU_PASS_B;  // rt rides on the alu result
                        use_rt      = 1'b1;
                    end
                    FN_HLT: ctrl.halt = 1'b1;
                    default: ;
                endcase
            end
            OP_ADI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                use_rs         = 1'b1;
            end
            OP_LHI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
            end
            OP_LWD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                use_rs          = 1'b1;
            end
            OP_SWD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                use_rs         = 1'b1;
                use_rt         = 1'b1;  // store data
            end
            OP_BNE, OP_BEQ: begin
                is_branch = 1'b1;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
            end
            OP_JMP: is_jump = 1'b1;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // hazards

    // load in execute, nothing to forward yet
    assign load_hit = inst_valid & ex_valid & ex_ctrl.mem_read
                    & ((use_rs & ex_dest == rs) | (use_rt & ex_dest == rt));

    // branch against a load still in the memory stage
    assign mem_pending = inst_valid & is_branch & mem_fwd.reg_write & ~mem_fwd.valid
                       & (mem_fwd.dest == rs | mem_fwd.dest == rt);

    assign stall = load_hit | mem_pending;

    // branch operands, youngest producer wins
    assign ex_fwd = ex_valid & ex_res.valid & ex_res.reg_write;
    assign mem_ok = mem_fwd.valid & mem_fwd.reg_write;

    always_comb begin
        br_a = rs_data;
        br_b = rt_data;
        if (mem_ok && mem_fwd.dest == rs) br_a = mem_fwd.data;
        if (mem_ok && mem_fwd.dest == rt) br_b = mem_fwd.data;
        if (ex_fwd && ex_res.dest == rs) br_a = ex_res.data;
        if (ex_fwd && ex_res.dest == rt) br_b = ex_res.data;
    end

    assign taken  = is_branch & ((opcode == OP_BEQ) ? (br_a == br_b) : (br_a != br_b));
    assign target = is_jump ? {pc[`WORD_WIDTH-1:`JMP_WIDTH], inst[`JMP_FIELD]}
                            : pc + 1'b1 + imm_ext;

    assign redirect  = inst_valid & ~stall & (is_jump | taken) & (target != pc + 1'b1);
    assign halt_seen = inst_valid & ctrl.halt;

    always_comb begin
        id_ex_out.ctrl    = ctrl;
        id_ex_out.rs_data = rs_data;
        id_ex_out.rt_data = rt_data;
        id_ex_out.imm     = imm_ext;
        id_ex_out.rs      = rs;
        id_ex_out.rt      = rt;
        id_ex_out.dest    = dest;
    end

endmodule

`default_nettype wire

/* design/execute_unit.sv */
`default_nettype none

`include "cpu_defines.svh"

module execute_unit (
    input  cpu_pkg::id_ex_t  id_ex_in,
    wb_bus_if.sink           mem_fwd,
    wb_bus_if.sink           wb_res,
    wb_bus_if.source         ex_res,
    output cpu_pkg::ex_mem_t ex_mem_out
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t result;
    logic  mem_ok;
    logic  wb_ok;

    assign mem_ok = mem_fwd.valid & mem_fwd.reg_write;
    assign wb_ok  = wb_res.valid & wb_res.reg_write;

    // memory stage checked last so it takes priority
    always_comb begin
        op_a = id_ex_in.rs_data;
        op_b = id_ex_in.rt_data;
        if (wb_ok && wb_res.dest == id_ex_in.rs) op_a = wb_res.data;
        if (wb_ok && wb_res.dest == id_ex_in.rt) op_b = wb_res.data;
        if (mem_ok && mem_fwd.dest == id_ex_in.rs) op_a = mem_fwd.data;
        if (mem_ok && mem_fwd.dest == id_ex_in.rt) op_b = mem_fwd.data;
    end

    always_comb begin
        if (!id_ex_in.ctrl.alu_src) begin
            alu_b = op_b;
        end else if (id_ex_in.ctrl.alu_op == ALU_PASS_B) begin
            alu_b = {id_ex_in.imm[`IMM_WIDTH-1:0], {`IMM_WIDTH{1'b0}}};  // lhi
        end else begin
            alu_b = id_ex_in.imm;
        end
    end

    always_comb begin
        case (id_ex_in.ctrl.alu_op)
            ALU_ADD:    result = op_a + alu_b;
            ALU_SUB:    result = op_a - alu_b;
            ALU_AND:    result = op_a & alu_b;
            ALU_OR:     result = op_a | alu_b;
            ALU_PASS_B: result = alu_b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        ex_mem_out.ctrl       = id_ex_in.ctrl;
        ex_mem_out.alu_result = result;
        ex_mem_out.store_data = op_b;
        ex_mem_out.dest       = id_ex_in.dest;
    end

    // a load has only its address here
    assign ex_res.valid     = ~id_ex_in.ctrl.mem_read;
    assign ex_res.reg_write = id_ex_in.ctrl.reg_write;
    assign ex_res.dest      = id_ex_in.dest;
    assign ex_res.data      = result;

endmodule

`default_nettype wire

/* design/cpu_core.sv */
`default_nettype none

`include "cpu_defines.svh"

module cpu_core (
    input  logic           clk,
    input  logic           reset_n,
    output cpu_pkg::word_t inst_addr,
    input  cpu_pkg::word_t inst_data,
    output logic           data_read,
    output logic           data_write,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_wdata,
    input  cpu_pkg::word_t data_rdata,
    output cpu_pkg::word_t num_inst,
    output cpu_pkg::word_t output_port,
    output logic           is_halted
);
    import cpu_pkg::*;

    word_t   pc;
    word_t   if_pc;
    word_t   if_inst;
    logic    if_valid;
    logic    fetch_stop;
    logic    halted;
    word_t   rs_data;
    word_t   rt_data;
    logic    stall;
    logic    redirect;
    logic    halt_seen;
    word_t   target;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    logic    id_ex_valid;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    logic    ex_mem_valid;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;
    logic    mem_wb_valid;

    wb_bus_if ex_res ();
    wb_bus_if mem_fwd ();
    wb_bus_if wb_res ();

    ////////////////////////////////////////////////////////////////////////////
    // fetch

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc         <= `RESET_PC;
            if_valid   <= 1'b0;
            fetch_stop <= 1'b0;
        end else if (!halted && !stall) begin
            if (redirect) begin
                pc       <= target;
                if_valid <= 1'b0;  // drop the fall-through fetch
            end else if (halt_seen || fetch_stop) begin
                if_valid   <= 1'b0;
                fetch_stop <= 1'b1;
            end else begin
                pc       <= pc + 1'b1;
                if_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!halted && !stall) begin
            if_inst <= inst_data;
            if_pc   <= pc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode and execute

    register_file u_register_file (
        .clk     (clk),
        .reset_n (reset_n),
        .rs      (if_inst[`RS_FIELD]),
        .rt      (if_inst[`RT_FIELD]),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb_res.sink)
    );

    decode_unit u_decode_unit (
        .inst      (if_inst),
        .inst_valid(if_valid),
        .pc        (if_pc),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .ex_ctrl   (id_ex_q.ctrl),
        .ex_dest   (id_ex_q.dest),
        .ex_valid  (id_ex_valid),
        .ex_res    (ex_res.sink),
        .mem_fwd   (mem_fwd.sink),
        .id_ex_out (id_ex_d),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .halt_seen (halt_seen)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk      (clk),
        .reset_n  (reset_n),
        .hold     (halted),
        .bubble   (stall),
        .in_valid (if_valid),
        .in_data  (id_ex_d),
        .out_valid(id_ex_valid),
        .out_data (id_ex_q)
    );

    execute_unit u_execute_unit (
        .id_ex_in  (id_ex_q),
        .mem_fwd   (mem_fwd.sink),
        .wb_res    (wb_res.sink),
        .ex_res    (ex_res.source),
        .ex_mem_out(ex_mem_d)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk      (clk),
        .reset_n  (reset_n),
        .hold     (halted),
        .bubble   (1'b0),
        .in_valid (id_ex_valid),
        .in_data  (ex_mem_d),
        .out_valid(ex_mem_valid),
        .out_data (ex_mem_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory stage

    assign data_read  = ex_mem_valid & ex_mem_q.ctrl.mem_read;
    assign data_write = ex_mem_valid & ex_mem_q.ctrl.mem_write;
    assign data_addr  = ex_mem_q.alu_result;
    assign data_wdata = ex_mem_q.store_data;

    // load data isn't here yet, valid stays low for loads
    assign mem_fwd.valid     = ex_mem_valid & ~ex_mem_q.ctrl.mem_to_reg;
    assign mem_fwd.reg_write = ex_mem_valid & ex_mem_q.ctrl.reg_write;
    assign mem_fwd.dest      = ex_mem_q.dest;
    assign mem_fwd.data      = ex_mem_q.alu_result;

    always_comb begin
        mem_wb_d.ctrl       = ex_mem_q.ctrl;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = data_rdata;
        mem_wb_d.dest       = ex_mem_q.dest;
    end

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk      (clk),
        .reset_n  (reset_n),
        .hold     (halted),
        .bubble   (1'b0),
        .in_valid (ex_mem_valid),
        .in_data  (mem_wb_d),
        .out_valid(mem_wb_valid),
        .out_data (mem_wb_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // writeback

    assign wb_res.valid     = mem_wb_valid & ~halted;
    assign wb_res.reg_write = mem_wb_q.ctrl.reg_write;
    assign wb_res.dest      = mem_wb_q.dest;
    assign wb_res.data      = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.load_data
                                                       : mem_wb_q.alu_result;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halted      <= 1'b0;
            num_inst    <= '0;
            output_port <= '0;
        end else if (!halted && mem_wb_valid) begin
            num_inst <= num_inst + 1'b1;  // hlt counts too
            if (mem_wb_q.ctrl.halt) begin
                halted <= 1'b1;
            end
            if (mem_wb_q.ctrl.wwd) begin
                output_port <= mem_wb_q.alu_result;
            end
        end
    end

    assign is_halted = halted;

endmodule

`default_nettype wire

/* bench/cpu_properties.sv */
`default_nettype none

module cpu_properties (
    input logic           clk,
    input logic           reset_n,
    input logic           data_read,
    input logic           data_write,
    input logic           is_halted,
    input cpu_pkg::word_t num_inst
);

    int error_count = 0;

    // halt is sticky until the next reset
    halt_sticky: assert property (
        @(posedge clk) disable iff (reset_n) is_halted |=> is_halted
    ) else begin
        error_count++;
        $error("is_halted dropped without a reset");
    end

    mem_exclusive: assert property (
        @(posedge clk) disable iff (reset_n) !(data_read && data_write)
    ) else begin
        error_count++;
        $error("data_read and data_write high together");
    end

    count_step: assert property (
        @(posedge clk) disable iff (reset_n)
        1'b1 |=> (num_inst == $past(num_inst)) || (num_inst == $past(num_inst) + 16'd1)
    ) else begin
        error_count++;
        $error("num_inst moved by more than one");
    end

    count_frozen: assert property (
        @(posedge clk) disable iff (reset_n) is_halted |=> $stable(num_inst)
    ) else begin
        error_count++;
        $error("num_inst changed while halted");
    end

    // nothing can be in the memory stage yet
    quiet_start: assert property (
        @(posedge clk) $fell(reset_n) |-> !data_write
    ) else begin
        error_count++;
        $error("data_write high in the first cycle after reset");
    end

endmodule

`default_nettype wire

/* bench/cpu_tb.sv */
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    logic  clk;
    logic  reset_n;
    word_t inst_addr;
    word_t inst_data;
    logic  data_read;
    logic  data_write;
    word_t data_addr;
    word_t data_wdata;
    word_t data_rdata;
    word_t num_inst;
    word_t output_port;
    logic  is_halted;

    word_t imem      [256];
    word_t dmem      [256];
    word_t dmem_init [256];  // random contents before the run

    // program table as one queue per column
    word_t prog         [$];
    int    row_inst_end [$];
    int    row_wwd_end  [$];
    int    row_count    [$];
    int    row_mem_addr [$];  // -1 when no memory word is checked
    word_t row_mem_val  [$];
    int    wwd_addr     [$];  // -1 for a constant value
    word_t wwd_val      [$];

    cpu_core u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .inst_addr  (inst_addr),
        .inst_data  (inst_data),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .num_inst   (num_inst),
        .output_port(output_port),
        .is_halted  (is_halted)
    );

    bind cpu_core cpu_properties u_properties (
        .clk       (clk),
        .reset_n   (reset_n),
        .data_read (data_read),
        .data_write(data_write),
        .is_halted (is_halted),
        .num_inst  (num_inst)
    );

    // zero-wait memories
    assign inst_data  = imem[inst_addr[7:0]];
    assign data_rdata = data_read ? dmem[data_addr[7:0]] : '0;

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoding

    function automatic word_t rtype_word(funct_e fn, int rs, int rt, int rd);
        return {OP_RTYPE, 2'(rs), 2'(rt), 2'(rd), fn};
    endfunction

    function automatic word_t imm_word(opcode_e op, int rs, int rt, int imm);
        return {op, 2'(rs), 2'(rt), 8'(imm)};
    endfunction

    function automatic word_t jump_word(int target);
        return {OP_JMP, 12'(target)};
    endfunction

    function automatic word_t wwd_word(int r);
        return rtype_word(FN_WWD, r, r, 0);  // register in both fields
    endfunction

    function automatic word_t halt_word();
        return rtype_word(FN_HLT, 0, 0, 0);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // table building

    function automatic void append_inst(word_t w);
        prog.push_back(w);
    endfunction

    function automatic void emit_const(word_t v);
        wwd_addr.push_back(-1);
        wwd_val.push_back(v);
    endfunction

    // expected value is the initial memory word plus an offset
    function automatic void mem_plus(int addr, word_t offset);
        wwd_addr.push_back(addr);
        wwd_val.push_back(offset);
    endfunction

    function automatic void close_row(int count, int mem_addr, word_t mem_val);
        row_inst_end.push_back(prog.size());
        row_wwd_end.push_back(wwd_addr.size());
        row_count.push_back(count);
        row_mem_addr.push_back(mem_addr);
        row_mem_val.push_back(mem_val);
    endfunction

    function automatic void build_table();
        // dependent chain with every result forwarded
        append_inst(imm_word(OP_LHI, 0, 1, 8'h12));
        append_inst(imm_word(OP_ADI, 1, 1, 8'h34));
        append_inst(wwd_word(1));
        append_inst(imm_word(OP_ADI, 1, 2, -1));
        append_inst(rtype_word(FN_ADD, 1, 2, 3));
        append_inst(wwd_word(3));
        append_inst(rtype_word(FN_SUB, 3, 1, 0));
        append_inst(rtype_word(FN_AND, 0, 3, 2));
        append_inst(rtype_word(FN_ORR, 2, 0, 1));
        append_inst(wwd_word(1));
        append_inst(wwd_word(2));
        append_inst(halt_word());
        emit_const(16'h1234);
        emit_const(16'h2467);
        emit_const(16'h1233);
        emit_const(16'h0023);
        close_row(12, -1, 16'h0000);

        // load-use and branch on a fresh load
        append_inst(imm_word(OP_LWD, 0, 1, 3));
        append_inst(imm_word(OP_ADI, 1, 2, 5));
        append_inst(wwd_word(2));
        append_inst(imm_word(OP_LWD, 0, 3, 7));
        append_inst(imm_word(OP_ADI, 3, 2, -3));
        append_inst(wwd_word(2));
        append_inst(imm_word(OP_LWD, 0, 3, 3));      // r0 still zero
        append_inst(imm_word(OP_BEQ, 3, 1, 1));
        append_inst(imm_word(OP_LHI, 0, 2, 8'h44));  // skipped
        append_inst(imm_word(OP_ADI, 2, 2, 1));
        append_inst(wwd_word(2));
        append_inst(halt_word());
        mem_plus(3, 16'h0005);
        mem_plus(7, 16'hfffd);
        mem_plus(7, 16'hfffe);
        close_row(11, -1, 16'h0000);

        // store then load from the same address
        append_inst(imm_word(OP_LHI, 0, 1, 8'h5a));
        append_inst(imm_word(OP_ADI, 1, 1, 8'h3c));
        append_inst(imm_word(OP_ADI, 0, 2, 8'h20));
        append_inst(imm_word(OP_SWD, 2, 1, 4));
        append_inst(imm_word(OP_LWD, 2, 3, 4));
        append_inst(wwd_word(3));
        append_inst(imm_word(OP_ADI, 3, 3, 1));
        append_inst(wwd_word(3));
        append_inst(halt_word());
        emit_const(16'h5a3c);
        emit_const(16'h5a3d);
        close_row(9, 36, 16'h5a3c);

        // branches and a jump over poisoned paths
        append_inst(imm_word(OP_ADI, 0, 1, 1));
        append_inst(imm_word(OP_ADI, 0, 2, 1));
        append_inst(imm_word(OP_BNE, 1, 2, 2));   // not taken
        append_inst(wwd_word(1));
        append_inst(imm_word(OP_BEQ, 1, 2, 2));   // taken to 7
        append_inst(imm_word(OP_LHI, 0, 3, 8'h77));
        append_inst(wwd_word(3));
        append_inst(imm_word(OP_ADI, 0, 3, 2));
        append_inst(imm_word(OP_BNE, 3, 1, 1));   // taken to 10
        append_inst(imm_word(OP_LHI, 0, 3, 8'h99));
        append_inst(wwd_word(3));
        append_inst(jump_word(14));
        append_inst(imm_word(OP_LHI, 0, 3, 8'h66));
        append_inst(wwd_word(3));
        append_inst(imm_word(OP_BEQ, 3, 1, 1));   // not taken
        append_inst(imm_word(OP_ADI, 2, 2, 8'h10));
        append_inst(wwd_word(2));
        append_inst(halt_word());
        emit_const(16'h0001);
        emit_const(16'h0002);
        emit_const(16'h0011);
        close_row(13, -1, 16'h0000);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checking and running

    task automatic check(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic run_row(int r);
        int          lo;
        int          hi;
        int          wlo;
        int          whi;
        logic [31:0] rnd;
        word_t       got [$];
        word_t       prev;
        word_t       exp_v;
        logic        wr_en;
        word_t       wr_addr;
        word_t       wr_val;
        logic        done;
        word_t       held_addr;
        word_t       held_count;

        lo  = (r == 0) ? 0 : row_inst_end[r-1];
        hi  = row_inst_end[r];
        wlo = (r == 0) ? 0 : row_wwd_end[r-1];
        whi = row_wwd_end[r];

        for (int a = 0; a < 256; a++) begin
            rnd          = $urandom;
            imem[a]      = halt_word();  // runaway fetch halts
            dmem[a]      = rnd[15:0];
            dmem_init[a] = rnd[15:0];
        end
        for (int i = lo; i < hi; i++) begin
            imem[i-lo] = prog[i];
        end

        @(posedge clk);
        #1;
        reset_n = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        check("num_inst", num_inst, 16'h0000);
        check("output_port", output_port, 16'h0000);
        check("is_halted", word_t'(is_halted), 16'h0000);
        reset_n = 1'b0;

        prev = '0;
        do begin
            @(negedge clk);
            if (output_port !== prev) begin
                got.push_back(output_port);
                prev = output_port;
            end
            wr_en   = data_write;
            wr_addr = data_addr;
            wr_val  = data_wdata;
            done    = is_halted;
            @(posedge clk);
            #1;
            if (wr_en) begin
                dmem[wr_addr[7:0]] = wr_val;
            end
        end while (!done);

        check("wwd_count", word_t'(got.size()), word_t'(whi - wlo));
        for (int k = 0; k < got.size(); k++) begin
            exp_v = wwd_val[wlo+k];
            if (wwd_addr[wlo+k] >= 0) begin
                exp_v = dmem_init[wwd_addr[wlo+k]] + wwd_val[wlo+k];
            end
            check($sformatf("output_port change %0d", k), got[k], exp_v);
        end
        check("num_inst", num_inst, word_t'(row_count[r]));

        // core must stay frozen
        held_addr  = inst_addr;
        held_count = num_inst;
        repeat (20) begin
            @(negedge clk);
            check("is_halted", word_t'(is_halted), 16'h0001);
            check("inst_addr", inst_addr, held_addr);
            check("num_inst", num_inst, held_count);
        end

        if (row_mem_addr[r] >= 0) begin
            check($sformatf("dmem[%0d]", row_mem_addr[r]), dmem[row_mem_addr[r]],
                  row_mem_val[r]);
        end
    endtask

    initial begin
        #1;
        #(row_count.size() * 200 * 8);
        $display("Timeout: the core did not finish its programs in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk     = 1'b0;
        reset_n = 1'b1;  // reset level
        void'($urandom(32'h536f));
        build_table();
        for (int r = 0; r < row_count.size(); r++) begin
            run_row(r);
        end
        if (u_dut.u_properties.error_count != 0) begin
            $display("An assertion on the core's ports failed during the run");
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/cpu_pkg.sv
design/wb_bus_if.sv
design/pipe_reg.sv
design/register_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/cpu_core.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cpu_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cpu_tb \
    -f files.f \
    -Mdir obj_dir \
    -o cpu_sim

./obj_dir/cpu_sim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

# an assertion abort ends the run without the pass line
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without completing"
    exit 1
fi

exit 0
